/* list.f */
cpu_pkg.sv
regfile.sv
hilo.sv
instr_fetch.sv
decode_and_issue.sv
instr_exec.sv
ctrl.sv
cpu_core.sv
tb_cpu_core.sv

/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - regfile.sv
  - hilo.sv
  - instr_fetch.sv
  - decode_and_issue.sv
  - instr_exec.sv
  - ctrl.sv
  - cpu_core.sv
  - target: simulation
    files:
      - tb_cpu_core.sv

/* tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

// MIPS encodings
localparam logic [5:0] opc_beq   = 6'h04;
localparam logic [5:0] opc_bne   = 6'h05;
localparam logic [5:0] opc_addiu = 6'h09;
localparam logic [5:0] opc_lui   = 6'h0f;
localparam logic [5:0] opc_lw    = 6'h23;
localparam logic [5:0] opc_sw    = 6'h2b;
localparam logic [5:0] fn_mfhi   = 6'h10;
localparam logic [5:0] fn_mflo   = 6'h12;
localparam logic [5:0] fn_multu  = 6'h19;
localparam logic [5:0] fn_addu   = 6'h21;
localparam logic [5:0] fn_subu   = 6'h23;
localparam logic [5:0] fn_and    = 6'h24;
localparam logic [5:0] fn_or     = 6'h25;
localparam logic [5:0] fn_slt    = 6'h2a;

localparam logic [31:0] reset_pc = 32'h0000_0000;

logic        clk;
logic        rst;
logic        dstall;
logic [31:0] iaddr;
logic [31:0] irdata;
logic        dread;
logic        dwrite;
logic [31:0] daddr;
logic [31:0] dwdata;
logic [31:0] drdata;

logic [31:0] rom [64];
logic [31:0] ram [256];
int          emit_idx;
integer      seed;
logic        stall_enable;
logic        stall_next;
int          error_count;

logic [31:0] store_addr_q [$];
logic [31:0] store_data_q [$];
logic [31:0] exp_addr_q [$];
logic [31:0] exp_data_q [$];

cpu_core #(
	.RESET_PC ( reset_pc )
) DUT (
	.clk    ( clk    ),
	.rst    ( rst    ),
	.iaddr  ( iaddr  ),
	.irdata ( irdata ),
	.dread  ( dread  ),
	.dwrite ( dwrite ),
	.daddr  ( daddr  ),
	.dwdata ( dwdata ),
	.drdata ( drdata ),
	.dstall ( dstall )
);

// both memories answer in the same cycle
assign irdata = rom[iaddr[7:2]];
// read data only answers a read strobe
assign drdata = dread ? ram[daddr[9:2]] : 32'h0000_0000;

initial begin
	clk = 1'b0;
	forever #20 clk = ~clk;
end

always @(posedge clk) begin
	stall_next = stall_enable && (($random(seed) & 3) == 0);
	#2;
	dstall = stall_next;
end

// bus values are settled at the falling edge, an access completes when dstall is low
always @(negedge clk) begin
	if (!rst) begin
		if (dread && dwrite) begin
			$display("data bus error: read and write strobes were high together");
			$display("sim failed");
			$fatal(1, "data bus strobes overlap");
		end else if (dwrite && !dstall) begin
			ram[daddr[9:2]] = dwdata;
			store_addr_q.push_back(daddr);
			store_data_q.push_back(dwdata);
		end
	end
end

task automatic check_value(input string what, input logic [31:0] got,
	input logic [31:0] expected);
	if (got !== expected) begin
		error_count++;
		$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		$display("sim failed");
		$fatal(1, "first mismatch ends the run");
	end
endtask

function automatic logic [31:0] r_word(input logic [5:0] funct, input logic [4:0] rd,
	input logic [4:0] rs, input logic [4:0] rt);
	return {6'h00, rs, rt, rd, 5'b0, funct};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [31:0] word);
	rom[emit_idx] = word;
	emit_idx++;
endtask

task automatic emit_nops(input int count);
	for (int i = 0; i < count; i++)
		emit(32'h0000_0000);
endtask

// lui then addiu, upper half rounded for the sign-extended lower half
task automatic emit_const(input logic [4:0] rd, input logic [31:0] value);
	logic [31:0] upper;
	upper = (value + 32'h0000_8000) >> 16;
	emit(i_word(opc_lui, 5'd0, rd, upper[15:0]));
	emit(i_word(opc_addiu, rd, rd, value[15:0]));
endtask

task automatic emit_store(input logic [4:0] rt, input logic [15:0] addr);
	emit(i_word(opc_sw, 5'd0, rt, addr));
endtask

task automatic emit_load(input logic [4:0] rt, input logic [15:0] addr);
	emit(i_word(opc_lw, 5'd0, rt, addr));
endtask

// branch to itself plus its delay slot
task automatic finish_program;
	emit(i_word(opc_beq, 5'd0, 5'd0, 16'hffff));
	emit(32'h0000_0000);
endtask

task automatic begin_test(input logic stall_on);
	@(posedge clk);
	#2;
	rst = 1'b1;
	stall_enable = stall_on;
	store_addr_q.delete();
	store_data_q.delete();
	exp_addr_q.delete();
	exp_data_q.delete();
	for (int i = 0; i < 64; i++)
		rom[i] = 32'h0000_0000;
	for (int i = 0; i < 256; i++)
		ram[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
	emit_idx = 0;
endtask

// the core leaves reset fetching from the reset vector with the data bus idle
task automatic release_reset;
	repeat (4) @(posedge clk);
	#2;
	check_value("iaddr in reset", iaddr, reset_pc);
	check_value("dread in reset", {31'b0, dread}, 32'd0);
	check_value("dwrite in reset", {31'b0, dwrite}, 32'd0);
	rst = 1'b0;
endtask

task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
	exp_addr_q.push_back(addr);
	exp_data_q.push_back(data);
endtask

task automatic wait_for_stores(input int count);
	int cycles;
	cycles = 0;
	while (store_addr_q.size() < count && cycles < 1000) begin
		@(posedge clk);
		cycles++;
	end
	if (store_addr_q.size() < count) begin
		$display("timeout: the expected stores never arrived, %0d of %0d seen",
			store_addr_q.size(), count);
		$display("sim failed");
		$fatal(1, "stores missing");
	end
	// room for a stray store to show up
	cycles = 0;
	while (cycles < 30) begin
		@(posedge clk);
		cycles++;
	end
	check_value("number of stores", store_addr_q.size(), count);
endtask

task automatic compare_stores;
	wait_for_stores(exp_addr_q.size());
	foreach (exp_addr_q[i]) begin
		check_value($sformatf("store %0d address", i), store_addr_q[i], exp_addr_q[i]);
		check_value($sformatf("store %0d data", i), store_data_q[i], exp_data_q[i]);
	end
endtask

task automatic arithmetic_test;
	logic [31:0] a;
	logic [31:0] b;
	a = 32'h8765_4321;
	b = 32'h1234_abcd;
	begin_test(1'b0);
	emit_const(1, a);
	emit_const(2, b);
	emit(r_word(fn_addu, 3, 1, 2));
	emit_store(3, 16'h0040);
	emit(r_word(fn_subu, 4, 1, 2));
	emit_store(4, 16'h0044);
	emit(r_word(fn_and, 5, 1, 2));
	emit_store(5, 16'h0048);
	emit(r_word(fn_or, 6, 1, 2));
	emit_store(6, 16'h004c);
	emit(r_word(fn_slt, 7, 1, 2));
	emit_store(7, 16'h0050);
	emit(r_word(fn_slt, 8, 2, 1));
	emit_store(8, 16'h0054);
	emit(i_word(opc_addiu, 1, 9, 16'hfffb));
	emit_store(9, 16'h0058);
	emit(i_word(opc_lui, 0, 10, 16'hbeef));
	emit_store(10, 16'h005c);
	finish_program();
	expect_store(32'h40, a + b);
	expect_store(32'h44, a - b);
	expect_store(32'h48, a & b);
	expect_store(32'h4c, a | b);
	expect_store(32'h50, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
	expect_store(32'h54, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
	expect_store(32'h58, a + {{16{1'b1}}, 16'hfffb});
	expect_store(32'h5c, 32'hbeef_0000);
	release_reset();
	compare_stores();
endtask

// gap no-ops between each producer and its consumer
task automatic forwarding_run(input int gap, input logic [31:0] c,
	output logic [31:0] first, output logic [31:0] second);
	begin_test(1'b0);
	emit_const(1, c);
	emit_nops(gap);
	emit(r_word(fn_addu, 2, 1, 1));
	emit_nops(gap);
	emit(r_word(fn_subu, 3, 2, 1));
	emit_nops(gap);
	emit(i_word(opc_addiu, 3, 4, 16'h0077));
	emit_nops(gap);
	emit(r_word(fn_or, 5, 4, 2));
	emit_nops(gap);
	emit_store(5, 16'h0060);
	emit_nops(gap);
	emit_store(3, 16'h0064);
	finish_program();
	release_reset();
	wait_for_stores(2);
	check_value("first forwarding store address", store_addr_q[0], 32'h60);
	check_value("second forwarding store address", store_addr_q[1], 32'h64);
	first = store_data_q[0];
	second = store_data_q[1];
endtask

task automatic forwarding_test;
	logic [31:0] c;
	logic [31:0] sum;
	logic [31:0] pad_first;
	logic [31:0] pad_second;
	logic [31:0] got_first;
	logic [31:0] got_second;
	c = 32'h0001_2345;
	sum = c + c;
	forwarding_run(4, c, pad_first, pad_second);
	check_value("padded or result", pad_first, ((sum - c) + 32'h77) | sum);
	check_value("padded subu result", pad_second, sum - c);
	for (int gap = 0; gap < 3; gap++) begin
		forwarding_run(gap, c, got_first, got_second);
		check_value($sformatf("or result at distance %0d", gap + 1), got_first, pad_first);
		check_value($sformatf("subu result at distance %0d", gap + 1), got_second, pad_second);
	end
endtask

task automatic load_use_test(input logic stall_on);
	logic [31:0] first;
	logic [31:0] second;
	first = 32'h0bad_f00d;
	second = 32'h1357_9bdf;
	begin_test(stall_on);
	ram[32] = first;
	ram[33] = second;
	emit_const(2, 32'h0000_1111);
	emit_load(1, 16'h0080);
	emit(r_word(fn_addu, 3, 1, 2));
	emit_store(3, 16'h0090);
	emit_load(4, 16'h0084);
	emit_store(4, 16'h0094);
	emit_load(5, 16'h0090);
	emit(i_word(opc_addiu, 5, 6, 16'h0001));
	emit_store(6, 16'h0098);
	finish_program();
	expect_store(32'h90, first + 32'h1111);
	expect_store(32'h94, second);
	expect_store(32'h98, first + 32'h1112);
	release_reset();
	compare_stores();
endtask

task automatic branch_test;
	begin_test(1'b0);
	emit_const(1, 32'd5);
	emit_const(2, 32'd5);
	emit_const(3, 32'd9);
	// word 6, taken to word 9
	emit(i_word(opc_beq, 1, 2, 16'd2));
	emit_store(1, 16'h00a0);
	emit_store(3, 16'h00a4);
	// word 9, not taken
	emit(i_word(opc_bne, 1, 2, 16'd4));
	emit_store(2, 16'h00a8);
	emit_store(3, 16'h00ac);
	// word 12, taken to word 15
	emit(i_word(opc_bne, 1, 3, 16'd2));
	emit_store(3, 16'h00b0);
	emit_store(1, 16'h00b4);
	// word 15, not taken
	emit(i_word(opc_beq, 1, 3, 16'd2));
	emit_store(1, 16'h00b8);
	emit_store(2, 16'h00bc);
	finish_program();
	expect_store(32'ha0, 32'd5);
	expect_store(32'ha8, 32'd5);
	expect_store(32'hac, 32'd9);
	expect_store(32'hb0, 32'd9);
	expect_store(32'hb8, 32'd5);
	expect_store(32'hbc, 32'd5);
	release_reset();
	compare_stores();
endtask

task automatic hilo_test;
	logic [31:0] a;
	logic [31:0] b;
	logic [63:0] product;
	a = $random(seed);
	b = $random(seed);
	product = {32'b0, a} * {32'b0, b};
	begin_test(1'b0);
	emit_const(1, a);
	emit_const(2, b);
	emit(r_word(fn_multu, 0, 1, 2));
	emit(r_word(fn_mfhi, 3, 0, 0));
	emit(r_word(fn_mflo, 4, 0, 0));
	emit_store(3, 16'h00c0);
	emit_store(4, 16'h00c4);
	finish_program();
	expect_store(32'hc0, product[63:32]);
	expect_store(32'hc4, product[31:0]);
	release_reset();
	compare_stores();
endtask

initial begin
	rst = 1'b1;
	dstall = 1'b0;
	stall_enable = 1'b0;
	stall_next = 1'b0;
	seed = 32'hc47e;
	error_count = 0;
	emit_idx = 0;
	arithmetic_test();
	forwarding_test();
	load_use_test(1'b0);
	branch_test();
	hilo_test();
	load_use_test(1'b1);
	if (error_count == 0) begin
		$display("sim passed");
	end else begin
		$display("sim failed");
	end
	$finish;
end

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
	parameter cpu_pkg::uint32_t RESET_PC = 32'h0000_0000
)(
	input  logic             clk,
	input  logic             rst,
	output cpu_pkg::uint32_t iaddr,
	input  cpu_pkg::uint32_t irdata,
	output logic             dread,
	output logic             dwrite,
	output cpu_pkg::uint32_t daddr,
	output cpu_pkg::uint32_t dwdata,
	input  cpu_pkg::uint32_t drdata,
	input  logic             dstall
);

import cpu_pkg::*;

logic stall_if;
logic stall_id;
logic flush_id;
logic flush_ex;
logic load_use_stall;
logic branch_taken;
uint32_t branch_target;

reg_addr_t rf_raddr1;
reg_addr_t rf_raddr2;
uint32_t   rf_rdata1;
uint32_t   rf_rdata2;
logic      rf_we;

logic    hilo_we;
uint64_t hilo_wdata;
uint64_t hilo_rdata;

// decode outputs
uint32_t   d_rs_value;
uint32_t   d_rt_value;
uint32_t   d_imm;
uint32_t   d_branch_offset;
reg_addr_t d_dest;
alu_op_t   d_alu_op;
logic      d_use_imm;
logic      d_mem_read;
logic      d_mem_write;
logic      d_reg_write;
logic      d_branch_eq;
logic      d_branch_ne;
logic      d_is_multu;

// IF/ID
logic    if_id_valid;
uint32_t if_id_instr;
uint32_t if_id_pc;

// ID/EX
logic      id_ex_valid;
uint32_t   id_ex_pc;
uint32_t   id_ex_rs_value;
uint32_t   id_ex_rt_value;
uint32_t   id_ex_imm;
uint32_t   id_ex_branch_offset;
reg_addr_t id_ex_dest;
alu_op_t   id_ex_alu_op;
logic      id_ex_use_imm;
logic      id_ex_mem_read;
logic      id_ex_mem_write;
logic      id_ex_reg_write;
logic      id_ex_branch_eq;
logic      id_ex_branch_ne;
logic      id_ex_is_multu;

uint32_t alu_result;
uint32_t store_data;

// EX/MEM
logic      ex_mem_valid;
reg_addr_t ex_mem_dest;
logic      ex_mem_reg_write;
logic      ex_mem_mem_read;
logic      ex_mem_mem_write;
uint32_t   ex_mem_alu;
uint32_t   ex_mem_store;
uint32_t   mem_result;

// MEM/WB
logic      mem_wb_valid;
reg_addr_t mem_wb_dest;
logic      mem_wb_reg_write;
uint32_t   mem_wb_data;

ctrl ctrl_inst(
	.load_use_stall,
	.branch_taken,
	.dstall,
	.stall_if,
	.stall_id,
	.flush_id,
	.flush_ex
);

regfile regfile_inst(
	.clk,
	.rst,
	.raddr1 ( rf_raddr1   ),
	.raddr2 ( rf_raddr2   ),
	.rdata1 ( rf_rdata1   ),
	.rdata2 ( rf_rdata2   ),
	.we     ( rf_we       ),
	.waddr  ( mem_wb_dest ),
	.wdata  ( mem_wb_data )
);

hilo hilo_inst(
	.clk,
	.rst,
	.we    ( hilo_we    ),
	.wdata ( hilo_wdata ),
	.rdata ( hilo_rdata )
);

instr_fetch #(
	.RESET_PC ( RESET_PC )
) instr_fetch_inst (
	.clk,
	.rst,
	.stall    ( stall_if      ),
	.redirect ( branch_taken  ),
	.target   ( branch_target ),
	.pc       ( iaddr         )
);

// the fetched word is dropped when the branch in EX redirects
always_ff @(posedge clk) begin
	if(rst || flush_id) begin
		if_id_valid <= 1'b0;
		if_id_instr <= '0;
	end else if(!stall_id) begin
		if_id_valid <= 1'b1;
		if_id_instr <= irdata;
	end
end

always_ff @(posedge clk) begin
	if(!stall_id)
		if_id_pc <= iaddr;
end

// EX feeds the mem path of forwarding, MEM the wb path; WB goes through the regfile
decode_and_issue decode_issue_inst(
	.clk,
	.rst,
	.instr          ( if_id_instr                     ),
	.rf_raddr1,
	.rf_raddr2,
	.rf_rdata1,
	.rf_rdata2,
	.fwd_mem_rd     ( id_ex_dest                      ),
	.fwd_mem_we     ( id_ex_valid && id_ex_reg_write  ),
	.fwd_mem_data   ( alu_result                      ),
	.fwd_mem_load   ( id_ex_mem_read                  ),
	.fwd_wb_rd      ( ex_mem_dest                     ),
	.fwd_wb_we      ( ex_mem_valid && ex_mem_reg_write ),
	.fwd_wb_data    ( mem_result                      ),
	.rs_value       ( d_rs_value                      ),
	.rt_value       ( d_rt_value                      ),
	.imm            ( d_imm                           ),
	.dest           ( d_dest                          ),
	.alu_op         ( d_alu_op                        ),
	.use_imm        ( d_use_imm                       ),
	.mem_read       ( d_mem_read                      ),
	.mem_write      ( d_mem_write                     ),
	.reg_write      ( d_reg_write                     ),
	.branch_eq      ( d_branch_eq                     ),
	.branch_ne      ( d_branch_ne                     ),
	.is_multu       ( d_is_multu                      ),
	.branch_offset  ( d_branch_offset                 ),
	.load_use_stall
);

// pipeline between ID and EX
always_ff @(posedge clk) begin
	if(rst || flush_ex) begin
		id_ex_valid     <= 1'b0;
		id_ex_dest      <= '0;
		id_ex_alu_op    <= alu_none;
		id_ex_use_imm   <= 1'b0;
		id_ex_mem_read  <= 1'b0;
		id_ex_mem_write <= 1'b0;
		id_ex_reg_write <= 1'b0;
		id_ex_branch_eq <= 1'b0;
		id_ex_branch_ne <= 1'b0;
		id_ex_is_multu  <= 1'b0;
	end else if(!stall_id) begin
		id_ex_valid     <= if_id_valid;
		id_ex_dest      <= d_dest;
		id_ex_alu_op    <= d_alu_op;
		id_ex_use_imm   <= d_use_imm;
		id_ex_mem_read  <= d_mem_read;
		id_ex_mem_write <= d_mem_write;
		id_ex_reg_write <= d_reg_write;
		id_ex_branch_eq <= d_branch_eq;
		id_ex_branch_ne <= d_branch_ne;
		id_ex_is_multu  <= d_is_multu;
	end
end

always_ff @(posedge clk) begin
	if(!stall_id) begin
		id_ex_pc            <= if_id_pc;
		id_ex_rs_value      <= d_rs_value;
		id_ex_rt_value      <= d_rt_value;
		id_ex_imm           <= d_imm;
		id_ex_branch_offset <= d_branch_offset;
	end
end

instr_exec exec_inst(
	.clk,
	.rst,
	.stall         ( dstall              ),
	.pc            ( id_ex_pc            ),
	.rs_value      ( id_ex_rs_value      ),
	.rt_value      ( id_ex_rt_value      ),
	.imm           ( id_ex_imm           ),
	.alu_op        ( id_ex_alu_op        ),
	.use_imm       ( id_ex_use_imm       ),
	.branch_eq     ( id_ex_branch_eq     ),
	.branch_ne     ( id_ex_branch_ne     ),
	.is_multu      ( id_ex_is_multu      ),
	.branch_offset ( id_ex_branch_offset ),
	.alu_result,
	.store_data,
	.branch_taken,
	.branch_target,
	.hilo_rdata,
	.hilo_we,
	.hilo_wdata
);

// pipeline between EX and MEM
always_ff @(posedge clk) begin
	if(rst) begin
		ex_mem_valid     <= 1'b0;
		ex_mem_dest      <= '0;
		ex_mem_reg_write <= 1'b0;
		ex_mem_mem_read  <= 1'b0;
		ex_mem_mem_write <= 1'b0;
	end else if(!dstall) begin
		ex_mem_valid     <= id_ex_valid;
		ex_mem_dest      <= id_ex_dest;
		ex_mem_reg_write <= id_ex_reg_write;
		ex_mem_mem_read  <= id_ex_mem_read;
		ex_mem_mem_write <= id_ex_mem_write;
	end
end

always_ff @(posedge clk) begin
	if(!dstall) begin
		ex_mem_alu   <= alu_result;
		ex_mem_store <= store_data;
	end
end

// strobes stay up while dstall holds the access
assign dread  = ex_mem_valid && ex_mem_mem_read;
assign dwrite = ex_mem_valid && ex_mem_mem_write;
assign daddr  = ex_mem_alu;
assign dwdata = ex_mem_store;

assign mem_result = ex_mem_mem_read ? drdata : ex_mem_alu;

// pipeline between MEM and WB
always_ff @(posedge clk) begin
	if(rst) begin
		mem_wb_valid     <= 1'b0;
		mem_wb_dest      <= '0;
		mem_wb_reg_write <= 1'b0;
	end else if(!dstall) begin
		mem_wb_valid     <= ex_mem_valid;
		mem_wb_dest      <= ex_mem_dest;
		mem_wb_reg_write <= ex_mem_reg_write;
	end
end

always_ff @(posedge clk) begin
	if(!dstall)
		mem_wb_data <= mem_result;
end

// write back
assign rf_we = mem_wb_valid && mem_wb_reg_write && !dstall;

dbus_exclusive: assert property (@(posedge clk) disable iff (rst) !(dread && dwrite));

endmodule

`default_nettype wire

/* ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl(
	input  logic load_use_stall,
	input  logic branch_taken,
	input  logic dstall,
	output logic stall_if,
	output logic stall_id,
	output logic flush_id,
	output logic flush_ex
);

// dstall freezes the whole pipe, a redirect overrides only the load-use hold
assign stall_if = dstall || (load_use_stall && !branch_taken);
assign stall_id = dstall || load_use_stall;
assign flush_id = branch_taken && !dstall;
assign flush_ex = load_use_stall && !dstall;

// a branch and a load can never both sit in EX
always_comb begin
	one_ex_event: assert #0 (!(load_use_stall && branch_taken));
end

endmodule

`default_nettype wire

/* instr_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_exec(
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  cpu_pkg::uint32_t pc,
	input  cpu_pkg::uint32_t rs_value,
	input  cpu_pkg::uint32_t rt_value,
	input  cpu_pkg::uint32_t imm,
	input  cpu_pkg::alu_op_t alu_op,
	input  logic             use_imm,
	input  logic             branch_eq,
	input  logic             branch_ne,
	input  logic             is_multu,
	input  cpu_pkg::uint32_t branch_offset,
	output cpu_pkg::uint32_t alu_result,
	output cpu_pkg::uint32_t store_data,
	output logic             branch_taken,
	output cpu_pkg::uint32_t branch_target,
	input  cpu_pkg::uint64_t hilo_rdata,
	output logic             hilo_we,
	output cpu_pkg::uint64_t hilo_wdata
);

import cpu_pkg::*;

uint32_t operand_b;
uint64_t product;
uint64_t last_product;
logic    last_valid;
uint64_t hilo_value;

assign operand_b = use_imm ? imm : rt_value;
assign product   = {32'b0, rs_value} * {32'b0, rt_value};

// multu leaves EX and lands in HI/LO at the same edge
assign hilo_we    = is_multu && !stall;
assign hilo_wdata = product;

// copy of the product for the instruction right behind multu
always_ff @(posedge clk) begin
	if(rst)
		last_valid <= 1'b0;
	else if(!stall)
		last_valid <= is_multu;
end

always_ff @(posedge clk) begin
	if(is_multu && !stall)
		last_product <= product;
end

assign hilo_value = last_valid ? last_product : hilo_rdata;

always_comb begin
	case(alu_op)
		alu_add:  alu_result = rs_value + operand_b;
		alu_sub:  alu_result = rs_value - operand_b;
		alu_and:  alu_result = rs_value & operand_b;
		alu_or:   alu_result = rs_value | operand_b;
		alu_slt:  alu_result = {31'b0, $signed(rs_value) < $signed(operand_b)};
		alu_lui:  alu_result = {imm[15:0], 16'b0};
		alu_mfhi: alu_result = hilo_value[63:32];
		alu_mflo: alu_result = hilo_value[31:0];
		default:  alu_result = '0;
	endcase
end

assign store_data = rt_value;

// target is relative to the delay slot
assign branch_taken  = (branch_eq && rs_value == rt_value) || (branch_ne && rs_value != rt_value);
assign branch_target = pc + 32'd4 + branch_offset;

endmodule

`default_nettype wire

/* decode_and_issue.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_and_issue(
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::uint32_t   instr,
	output cpu_pkg::reg_addr_t rf_raddr1,
	output cpu_pkg::reg_addr_t rf_raddr2,
	input  cpu_pkg::uint32_t   rf_rdata1,
	input  cpu_pkg::uint32_t   rf_rdata2,
	input  cpu_pkg::reg_addr_t fwd_mem_rd,
	input  logic               fwd_mem_we,
	input  cpu_pkg::uint32_t   fwd_mem_data,
	input  logic               fwd_mem_load,
	input  cpu_pkg::reg_addr_t fwd_wb_rd,
	input  logic               fwd_wb_we,
	input  cpu_pkg::uint32_t   fwd_wb_data,
	output cpu_pkg::uint32_t   rs_value,
	output cpu_pkg::uint32_t   rt_value,
	output cpu_pkg::uint32_t   imm,
	output cpu_pkg::reg_addr_t dest,
	output cpu_pkg::alu_op_t   alu_op,
	output logic               use_imm,
	output logic               mem_read,
	output logic               mem_write,
	output logic               reg_write,
	output logic               branch_eq,
	output logic               branch_ne,
	output logic               is_multu,
	output cpu_pkg::uint32_t   branch_offset,
	output logic               load_use_stall
);

import cpu_pkg::*;

opcode_t   opcode;
funct_t    funct;
reg_addr_t rs;
reg_addr_t rt;
logic      uses_rs;
logic      uses_rt;

assign opcode    = opcode_t'(instr[31:26]);
assign funct     = funct_t'(instr[5:0]);
assign rs        = instr[25:21];
assign rt        = instr[20:16];
assign rf_raddr1 = rs;
assign rf_raddr2 = rt;

// instruction in EX is younger than the one in MEM
function automatic uint32_t pick_operand(input reg_addr_t addr, input uint32_t rf_value);
	if(addr == '0)
		return '0;
	if(fwd_mem_we && fwd_mem_rd == addr)
		return fwd_mem_data;
	if(fwd_wb_we && fwd_wb_rd == addr)
		return fwd_wb_data;
	return rf_value;
endfunction

always_comb begin
	rs_value = pick_operand(rs, rf_rdata1);
	rt_value = pick_operand(rt, rf_rdata2);
end

always_comb begin
	imm           = {{16{instr[15]}}, instr[15:0]};
	branch_offset = {{14{instr[15]}}, instr[15:0], 2'b00};
	dest          = rt;
	alu_op        = alu_none;
	use_imm       = 1'b0;
	mem_read      = 1'b0;
	mem_write     = 1'b0;
	branch_eq     = 1'b0;
	branch_ne     = 1'b0;
	is_multu      = 1'b0;
	uses_rs       = 1'b1;
	uses_rt       = 1'b0;
	case(opcode)
		op_special: begin
			dest    = instr[15:11];
			uses_rt = 1'b1;
			case(funct)
				fn_addu:  alu_op = alu_add;
				fn_subu:  alu_op = alu_sub;
				fn_and:   alu_op = alu_and;
				fn_or:    alu_op = alu_or;
				fn_slt:   alu_op = alu_slt;
				fn_mfhi:  alu_op = alu_mfhi;
				fn_mflo:  alu_op = alu_mflo;
				fn_multu: is_multu = 1'b1;
				default:  alu_op = alu_none;
			endcase
		end
		op_addiu: begin
			alu_op  = alu_add;
			use_imm = 1'b1;
		end
		op_lui: begin
			alu_op  = alu_lui;
			uses_rs = 1'b0;
		end
		op_lw: begin
			alu_op   = alu_add;
			use_imm  = 1'b1;
			mem_read = 1'b1;
		end
		op_sw: begin
			alu_op    = alu_add;
			use_imm   = 1'b1;
			mem_write = 1'b1;
			uses_rt   = 1'b1;
		end
		op_beq: begin
			branch_eq = 1'b1;
			uses_rt   = 1'b1;
		end
		op_bne: begin
			branch_ne = 1'b1;
			uses_rt   = 1'b1;
		end
		default: uses_rs = 1'b0;
	endcase
	// sw only computes an address and writes no register
	reg_write = (alu_op != alu_none) && !mem_write;
end

// a load in EX has no data yet
assign load_use_stall = fwd_mem_load && fwd_mem_we && fwd_mem_rd != '0
	&& ((uses_rs && fwd_mem_rd == rs) || (uses_rt && fwd_mem_rd == rt));

// one bubble later the load has moved on to MEM
load_use_resolves: assert property (@(posedge clk) disable iff (rst)
	load_use_stall |=> (load_use_stall || fwd_wb_rd == $past(fwd_mem_rd)));

endmodule

`default_nettype wire

/* instr_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
	parameter cpu_pkg::uint32_t RESET_PC = 32'h0000_0000
)(
	input  logic             clk,
	input  logic             rst,
	input  logic             stall,
	input  logic             redirect,
	input  cpu_pkg::uint32_t target,
	output cpu_pkg::uint32_t pc
);

// ctrl lets a redirect through a load-use stall, never through dstall
always_ff @(posedge clk) begin
	if(rst)
		pc <= RESET_PC;
	else if(stall)
		pc <= pc;
	else if(redirect)
		pc <= target;
	else
		pc <= pc + 32'd4;
end

pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hilo.sv */
`timescale 1ns/1ps
`default_nettype none

module hilo(
	input  logic             clk,
	input  logic             rst,
	input  logic             we,
	input  cpu_pkg::uint64_t wdata,
	output cpu_pkg::uint64_t rdata
);

// {hi, lo}
always_ff @(posedge clk) begin
	if(rst)
		rdata <= '0;
	else if(we)
		rdata <= wdata;
end

endmodule

`default_nettype wire

/* regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile(
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	output cpu_pkg::uint32_t   rdata1,
	output cpu_pkg::uint32_t   rdata2,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::uint32_t   wdata
);

import cpu_pkg::*;

uint32_t regs [32];

// register 0 is cleared by reset and never written
always_ff @(posedge clk) begin
	if(rst)
		regs[0] <= '0;
	else if(we && waddr != '0)
		regs[waddr] <= wdata;
end

// write-through so a reader in the same cycle sees the new value
assign rdata1 = (we && waddr != '0 && waddr == raddr1) ? wdata : regs[raddr1];
assign rdata2 = (we && waddr != '0 && waddr == raddr2) ? wdata : regs[raddr2];

zero_reg_kept: assert property (@(posedge clk) disable iff (rst)
	(we && waddr == '0) |=> (raddr1 != '0 || rdata1 == '0));

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [63:0] uint64_t;
typedef logic [4:0]  reg_addr_t;

// primary opcode, bits 31:26
typedef enum logic [5:0] {
	op_special = 6'h00,
	op_beq     = 6'h04,
	op_bne     = 6'h05,
	op_addiu   = 6'h09,
	op_lui     = 6'h0f,
	op_lw      = 6'h23,
	op_sw      = 6'h2b
} opcode_t;

// function field of special, bits 5:0
typedef enum logic [5:0] {
	fn_mfhi  = 6'h10,
	fn_mflo  = 6'h12,
	fn_multu = 6'h19,
	fn_addu  = 6'h21,
	fn_subu  = 6'h23,
	fn_and   = 6'h24,
	fn_or    = 6'h25,
	fn_slt   = 6'h2a
} funct_t;

typedef enum logic [3:0] {
	alu_none,
	alu_add,
	alu_sub,
	alu_and,
	alu_or,
	alu_slt,
	alu_lui,
	alu_mfhi,
	alu_mflo
} alu_op_t;

endpackage

`default_nettype wire
